//--- rtl/rc4_pkg.sv
`default_nettype none

package rc4_pkg;

	typedef logic [7:0] byte_t;		// one byte of state, cipher or plain memory
	typedef logic [7:0] saddr_t;	// state memory address, 256 entries
	typedef logic [4:0] maddr_t;	// message memory address, 32 entries
	typedef logic [23:0] key_t;		// byte 0 in [23:16], byte 1 in [15:8], byte 2 in [7:0]

	// message and key geometry
	localparam int MSG_LEN = 32;
	localparam int KEY_BYTES = 3;	// key bytes cycle through the schedule

	// top of the search range, only 22 bits of key are searched
	localparam key_t KEY_LAST = 24'h3F_FFFF;

	// accepted plaintext bytes
	localparam byte_t CHAR_LO = 8'h61;		// 'a'
	localparam byte_t CHAR_HI = 8'h7A;		// 'z'
	localparam byte_t CHAR_SPACE = 8'h20;	// ' '

	// search controller states
	typedef enum logic [2:0]
	{
		IDLE,	// waiting for start
		INIT,	// identity fill of s
		KSA,	// key schedule swaps
		PRGA,	// keystream, decrypt and check
		DONE	// result held until next start
	} search_state_t;

endpackage

`default_nettype wire

//--- rtl/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// one engine's port into the 256 byte state memory
interface mem_bus_if;
	import rc4_pkg::*;

	saddr_t addr;	// shared by read and write
	byte_t wdata;
	logic wren;
	byte_t rdata;	// registered, one cycle after addr

	modport engine (output addr, output wdata, output wren, input rdata);
	modport mem (input addr, input wdata, input wren, output rdata);

endinterface

`default_nettype wire

//--- rtl/sync_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
	parameter int ADDR_W = 8	// 8 for state memory, 5 for message memories
)
(
	input wire clk,
	input wire [ADDR_W-1:0] waddr,
	input wire rc4_pkg::byte_t wdata,
	input wire wren,
	input wire [ADDR_W-1:0] raddr,
	output rc4_pkg::byte_t rdata
);
	import rc4_pkg::*;

	byte_t mem [2**ADDR_W];	// contents undefined until written

	always_ff @(posedge clk)
	begin
		if (wren)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];	// old data on a same-address write
	end

endmodule

`default_nettype wire

//--- rtl/s_init_engine.sv
`timescale 1ns/1ps
`default_nettype none

module s_init_engine
(
	input wire clk,
	input wire reset,
	input wire start,
	output logic done,
	mem_bus_if.engine bus
);
	import rc4_pkg::*;

	saddr_t i;		// fill index, also the value written
	logic active;

	// s[i] = i, one byte per cycle
	assign bus.addr = i;
	assign bus.wdata = byte_t'(i);
	assign bus.wren = active;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			i <= '0;
			active <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)	// a new start restarts a run that is still going
			begin
				i <= '0;
				active <= 1'b1;
			end
			else if (active)
			begin
				i <= i + 1'b1;
				if (i == 8'hFF)	// last write this cycle
				begin
					active <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/ksa_engine.sv
`timescale 1ns/1ps
`default_nettype none

module ksa_engine
(
	input wire clk,
	input wire reset,
	input wire start,
	input wire rc4_pkg::key_t key,
	output logic done,
	mem_bus_if.engine bus
);
	import rc4_pkg::*;

	// four cycles per i, built around the one cycle read latency
	typedef enum logic [2:0]
	{
		K_IDLE,
		K_RD_I,		// present i
		K_GET_I,	// s[i] back, compute j and present it
		K_WR_J,		// s[j] back, write s[j] = s[i]
		K_WR_I		// write s[i] = s[j]
	} ksa_state_t;

	ksa_state_t state;
	saddr_t i;
	saddr_t j;
	logic [1:0] kidx;	// i mod 3
	byte_t kbyte;
	byte_t si;			// held copy of s[i]
	byte_t sj;			// held copy of s[j]
	saddr_t j_next;

	always_comb
	begin
		case (kidx)
			2'd0: kbyte = key[23:16];
			2'd1: kbyte = key[15:8];
			default: kbyte = key[7:0];
		endcase
	end

	assign j_next = j + bus.rdata + kbyte;	// only meaningful in K_GET_I

	always_comb
	begin
		bus.addr = i;		// K_RD_I and K_WR_I
		bus.wdata = sj;
		bus.wren = 1'b0;
		case (state)
			K_GET_I: bus.addr = j_next;	// read s[j] straight away
			K_WR_J:
			begin
				bus.addr = j;
				bus.wdata = si;
				bus.wren = 1'b1;
			end
			K_WR_I: bus.wren = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= K_IDLE;
			i <= '0;
			j <= '0;
			kidx <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				i <= '0;
				j <= '0;
				kidx <= '0;
				state <= K_RD_I;
			end
			else
			begin
				case (state)
					K_RD_I: state <= K_GET_I;
					K_GET_I:
					begin
						j <= j_next;
						state <= K_WR_J;
					end
					K_WR_J: state <= K_WR_I;
					K_WR_I:
					begin
						i <= i + 1'b1;
						kidx <= (kidx == 2'(KEY_BYTES - 1)) ? 2'd0 : kidx + 1'b1;
						if (i == 8'hFF)	// swap of the last entry just written
						begin
							done <= 1'b1;
							state <= K_IDLE;
						end
						else
							state <= K_RD_I;
					end
					default: state <= K_IDLE;
				endcase
			end
		end
	end

	// swap payload, no reset
	always_ff @(posedge clk)
	begin
		if (state == K_GET_I)
			si <= bus.rdata;
		if (state == K_WR_J)
			sj <= bus.rdata;
	end

endmodule

`default_nettype wire

//--- rtl/prga_engine.sv
`timescale 1ns/1ps
`default_nettype none

module prga_engine
(
	input wire clk,
	input wire reset,
	input wire start,
	output logic done,
	output logic valid,
	mem_bus_if.engine bus,
	output rc4_pkg::maddr_t cipher_addr,
	input wire rc4_pkg::byte_t cipher_data,
	output rc4_pkg::maddr_t plain_addr,
	output rc4_pkg::byte_t plain_data,
	output logic plain_wr
);
	import rc4_pkg::*;

	// six cycles per message byte
	typedef enum logic [2:0]
	{
		P_IDLE,
		P_RD_I,		// i = i + 1, present it
		P_GET_I,	// s[i] back, j = j + s[i], present j
		P_WR_J,		// s[j] back, write s[j] = s[i]
		P_WR_I,		// write s[i] = s[j]
		P_RD_T,		// present s[i] + s[j]
		P_GET_T		// keystream byte back, decrypt and check
	} prga_state_t;

	prga_state_t state;
	saddr_t i;
	saddr_t j;
	maddr_t k;			// message byte index
	byte_t si;
	byte_t sj;
	saddr_t i_inc;
	saddr_t j_next;
	logic char_ok;

	assign i_inc = i + 1'b1;
	assign j_next = j + bus.rdata;	// used in P_GET_I

	always_comb
	begin
		bus.addr = i;
		bus.wdata = sj;
		bus.wren = 1'b0;
		case (state)
			P_RD_I: bus.addr = i_inc;
			P_GET_I: bus.addr = j_next;
			P_WR_J:
			begin
				bus.addr = j;
				bus.wdata = si;
				bus.wren = 1'b1;
			end
			P_WR_I: bus.wren = 1'b1;	// s[i] = s[j]
			P_RD_T: bus.addr = si + sj;
			default: ;
		endcase
	end

	// cipher byte k is ready long before P_GET_T
	assign cipher_addr = k;
	assign plain_addr = k;
	assign plain_data = bus.rdata ^ cipher_data;
	assign plain_wr = (state == P_GET_T);

	// lower case letter or space
	assign char_ok = ((plain_data >= CHAR_LO) && (plain_data <= CHAR_HI))
		|| (plain_data == CHAR_SPACE);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= P_IDLE;
			i <= '0;
			j <= '0;
			k <= '0;
			done <= 1'b0;
			valid <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				i <= '0;
				j <= '0;
				k <= '0;
				valid <= 1'b0;
				state <= P_RD_I;
			end
			else
			begin
				case (state)
					P_RD_I:
					begin
						i <= i_inc;
						state <= P_GET_I;
					end
					P_GET_I:
					begin
						j <= j_next;
						state <= P_WR_J;
					end
					P_WR_J: state <= P_WR_I;
					P_WR_I: state <= P_RD_T;
					P_RD_T: state <= P_GET_T;
					P_GET_T:
					begin
						if (!char_ok)	// bad byte, give up on this key
						begin
							done <= 1'b1;
							valid <= 1'b0;
							state <= P_IDLE;
						end
						else if (k == maddr_t'(MSG_LEN - 1))
						begin
							done <= 1'b1;
							valid <= 1'b1;	// whole message readable
							state <= P_IDLE;
						end
						else
						begin
							k <= k + 1'b1;
							state <= P_RD_I;
						end
					end
					default: state <= P_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == P_GET_I)
			si <= bus.rdata;
		if (state == P_WR_J)
			sj <= bus.rdata;
	end

endmodule

`default_nettype wire

//--- rtl/key_search.sv
`timescale 1ns/1ps
`default_nettype none

module key_search
(
	input wire clk,
	input wire reset,
	input wire start,
	input wire stop,
	input wire rc4_pkg::key_t key_start,
	output rc4_pkg::key_t key,
	output logic busy,
	output logic done,
	output logic found,
	mem_bus_if.mem init_bus,
	mem_bus_if.mem ksa_bus,
	mem_bus_if.mem prga_bus,
	mem_bus_if.engine s_bus,
	output logic init_start,
	output logic ksa_start,
	output logic prga_start,
	input wire init_done,
	input wire ksa_done,
	input wire prga_done,
	input wire prga_valid
);
	import rc4_pkg::*;

	search_state_t state;

	assign busy = (state == INIT) || (state == KSA) || (state == PRGA);
	assign done = (state == DONE);

	// read data fans out to every engine, only the owner uses it
	assign init_bus.rdata = s_bus.rdata;
	assign ksa_bus.rdata = s_bus.rdata;
	assign prga_bus.rdata = s_bus.rdata;

	// state memory goes to the engine of the current phase
	always_comb
	begin
		s_bus.addr = prga_bus.addr;
		s_bus.wdata = prga_bus.wdata;
		s_bus.wren = 1'b0;	// no writes outside a phase
		case (state)
			INIT:
			begin
				s_bus.addr = init_bus.addr;
				s_bus.wdata = init_bus.wdata;
				s_bus.wren = init_bus.wren;
			end
			KSA:
			begin
				s_bus.addr = ksa_bus.addr;
				s_bus.wdata = ksa_bus.wdata;
				s_bus.wren = ksa_bus.wren;
			end
			PRGA: s_bus.wren = prga_bus.wren;
			default: ;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			key <= '0;
			found <= 1'b0;
			init_start <= 1'b0;
			ksa_start <= 1'b0;
			prga_start <= 1'b0;
		end
		else
		begin
			init_start <= 1'b0;	// strobes last one cycle
			ksa_start <= 1'b0;
			prga_start <= 1'b0;
			if (stop)
			begin
				found <= 1'b0;
				state <= DONE;
			end
			else
			begin
				case (state)
					IDLE, DONE:
					begin
						if (start)
						begin
							key <= key_start;
							found <= 1'b0;
							init_start <= 1'b1;
							state <= INIT;
						end
					end
					INIT:
					begin
						if (init_done)
						begin
							ksa_start <= 1'b1;
							state <= KSA;
						end
					end
					KSA:
					begin
						if (ksa_done)
						begin
							prga_start <= 1'b1;
							state <= PRGA;
						end
					end
					PRGA:
					begin
						if (prga_done)
						begin
							if (prga_valid)
							begin
								found <= 1'b1;
								state <= DONE;
							end
							else if (key == KEY_LAST)	// range exhausted
								state <= DONE;
							else
							begin
								key <= key + 1'b1;
								init_start <= 1'b1;
								state <= INIT;
							end
						end
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/rc4_cracker_top.sv
`timescale 1ns/1ps
`default_nettype none

module rc4_cracker_top
(
	input wire clk,
	input wire reset,
	input wire start,
	input wire stop,
	input wire rc4_pkg::key_t key_start,
	input wire cipher_wr,
	input wire rc4_pkg::maddr_t cipher_addr,
	input wire rc4_pkg::byte_t cipher_data,
	input wire rc4_pkg::maddr_t plain_addr,
	output rc4_pkg::byte_t plain_data,
	output rc4_pkg::key_t key,
	output logic busy,
	output logic done,
	output logic found
);
	import rc4_pkg::*;

	logic init_start;
	logic ksa_start;
	logic prga_start;
	logic init_done;
	logic ksa_done;
	logic prga_done;
	logic prga_valid;
	maddr_t prga_cipher_addr;	// prga side of the message memories
	byte_t prga_cipher_data;
	maddr_t prga_plain_addr;
	byte_t prga_plain_data;
	logic prga_plain_wr;

	mem_bus_if init_bus ();
	mem_bus_if ksa_bus ();
	mem_bus_if prga_bus ();
	mem_bus_if s_bus ();	// muxed bus at the state memory

	sync_ram #(.ADDR_W($bits(saddr_t))) s_mem_inst (
		.clk(clk), .waddr(s_bus.addr), .wdata(s_bus.wdata), .wren(s_bus.wren),
		.raddr(s_bus.addr), .rdata(s_bus.rdata));

	// written from the top ports, read by prga
	sync_ram #(.ADDR_W($bits(maddr_t))) cipher_mem_inst (
		.clk(clk), .waddr(cipher_addr), .wdata(cipher_data), .wren(cipher_wr),
		.raddr(prga_cipher_addr), .rdata(prga_cipher_data));

	// written by prga, read back through the top ports
	sync_ram #(.ADDR_W($bits(maddr_t))) plain_mem_inst (
		.clk(clk), .waddr(prga_plain_addr), .wdata(prga_plain_data), .wren(prga_plain_wr),
		.raddr(plain_addr), .rdata(plain_data));

	s_init_engine s_init_engine_inst (
		.clk(clk), .reset(reset), .start(init_start), .done(init_done), .bus(init_bus));

	ksa_engine ksa_engine_inst (
		.clk(clk), .reset(reset), .start(ksa_start), .key(key), .done(ksa_done),
		.bus(ksa_bus));

	prga_engine prga_engine_inst (
		.clk(clk), .reset(reset), .start(prga_start), .done(prga_done), .valid(prga_valid),
		.bus(prga_bus), .cipher_addr(prga_cipher_addr), .cipher_data(prga_cipher_data),
		.plain_addr(prga_plain_addr), .plain_data(prga_plain_data),
		.plain_wr(prga_plain_wr));

	key_search key_search_inst (
		.clk(clk), .reset(reset), .start(start), .stop(stop), .key_start(key_start),
		.key(key), .busy(busy), .done(done), .found(found),
		.init_bus(init_bus), .ksa_bus(ksa_bus), .prga_bus(prga_bus), .s_bus(s_bus),
		.init_start(init_start), .ksa_start(ksa_start), .prga_start(prga_start),
		.init_done(init_done), .ksa_done(ksa_done), .prga_done(prga_done),
		.prga_valid(prga_valid));

endmodule

`default_nettype wire

//--- bench/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker
(
	input wire clk,
	input wire reset,
	input wire start,
	input wire stop,
	input wire rc4_pkg::key_t key,
	input wire busy,
	input wire done,
	input wire found,
	input wire rc4_pkg::byte_t plain_data,
	input wire [8*12-1:0] test_name,	// ascii, for the error lines
	input wire idle_chk,				// compare the idle outputs on this edge
	input wire armed,					// compare the result when done rises
	input wire key_chk,					// key is known for this run
	input wire rc4_pkg::key_t exp_key,
	input wire exp_found,
	input wire plain_chk,				// compare plain_data on this edge
	input wire rc4_pkg::maddr_t plain_idx,
	input wire rc4_pkg::byte_t exp_plain,
	output int errors
);
	import rc4_pkg::*;

	logic done_q;		// done one edge ago, for the rising edge
	logic start_q;		// start strobe one edge ago
	int stop_cnt;		// edges seen since stop, 0 when not waiting
	int err_cnt = 0;

	assign errors = err_cnt;

	task automatic report_mismatch(input string what, input logic [23:0] expected,
		input logic [23:0] actual);
		$display("ERR %0s %0s: expected %0h actual %0h", test_name, what, expected, actual);
		err_cnt++;
	endtask

	always @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			done_q <= 1'b0;
			start_q <= 1'b0;
			stop_cnt <= 0;
		end
		else
		begin
			done_q <= done;
			start_q <= start;
			// outputs straight after reset
			if (idle_chk)
			begin
				if (busy !== 1'b0)
					report_mismatch("busy", 24'h0, {23'h0, busy});
				if (done !== 1'b0)
					report_mismatch("done", 24'h0, {23'h0, done});
				if (found !== 1'b0)
					report_mismatch("found", 24'h0, {23'h0, found});
				if (key !== '0)
					report_mismatch("key", 24'h0, key);
			end
			// search running one edge after the start strobe
			if (start_q)
			begin
				if (busy !== 1'b1)
					report_mismatch("busy", 24'h1, {23'h0, busy});
				if (done !== 1'b0)
					report_mismatch("done", 24'h0, {23'h0, done});
			end
			// result of a search, valid while done is high
			if (done && !done_q && armed)
			begin
				if (busy !== 1'b0)
				begin
					$display("%0s: busy still high when done rose", test_name);
					err_cnt++;
				end
				if (found !== exp_found)
					report_mismatch("found", {23'h0, exp_found}, {23'h0, found});
				if (key_chk && (key !== exp_key))
					report_mismatch("key", exp_key, key);
			end
			if (plain_chk && (plain_data !== exp_plain))
				report_mismatch($sformatf("plain[%0d]", plain_idx), {16'h0, exp_plain},
					{16'h0, plain_data});
			// stop must give done on one of the next two edges
			if (stop)
				stop_cnt <= 1;
			else if (stop_cnt != 0)
			begin
				if (done)
					stop_cnt <= 0;
				else if (stop_cnt == 2)
				begin
					$display("%0s: done did not follow stop within two cycles", test_name);
					err_cnt++;
					stop_cnt <= 0;
				end
				else
					stop_cnt <= stop_cnt + 1;
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
	import rc4_pkg::*;

	localparam int FIND_CASES = 4;
	// find cases up to 4 keys each, exhaustion 3, stop run about 2, restart 4
	localparam int KEYS_TOTAL = FIND_CASES * 4 + 3 + 2 + 4;
	localparam int WATCH_CYCLES = KEYS_TOTAL * 2000 + 5000;	// margin for loads and readback

	logic clk;
	logic reset;
	logic start;
	logic stop;
	key_t key_start;
	logic cipher_wr;
	maddr_t cipher_addr;
	byte_t cipher_data;
	maddr_t plain_addr;
	byte_t plain_data;
	key_t key;
	logic busy;
	logic done;
	logic found;

	// expectations handed to the checker
	logic [8*12-1:0] test_name;
	logic idle_chk;
	logic armed;
	logic key_chk;
	key_t exp_key;
	logic exp_found;
	logic plain_chk;
	maddr_t plain_idx;
	byte_t exp_plain;
	int errors;

	// reference model storage
	byte_t msg [MSG_LEN];		// original plaintext
	byte_t cipher [MSG_LEN];
	byte_t ks [MSG_LEN];		// keystream of the last key modelled
	byte_t s_model [256];
	key_t secret;
	key_t pred_key;
	logic pred_found;

	rc4_cracker_top rc4_cracker_top_inst (
		.clk(clk), .reset(reset), .start(start), .stop(stop), .key_start(key_start),
		.cipher_wr(cipher_wr), .cipher_addr(cipher_addr), .cipher_data(cipher_data),
		.plain_addr(plain_addr), .plain_data(plain_data), .key(key), .busy(busy),
		.done(done), .found(found));

	tb_checker checker_inst (
		.clk(clk), .reset(reset), .start(start), .stop(stop), .key(key), .busy(busy),
		.done(done), .found(found), .plain_data(plain_data), .test_name(test_name),
		.idle_chk(idle_chk), .armed(armed), .key_chk(key_chk), .exp_key(exp_key),
		.exp_found(exp_found), .plain_chk(plain_chk), .plain_idx(plain_idx),
		.exp_plain(exp_plain), .errors(errors));

	initial
		clk = 1'b0;
	always #50 clk = ~clk;	// 100 ns period

	// inputs change 5 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#5;
	endtask

	function automatic bit char_valid(input byte_t b);
		return ((b >= CHAR_LO) && (b <= CHAR_HI)) || (b == CHAR_SPACE);
	endfunction

	// plain RC4, first MSG_LEN keystream bytes into ks
	task automatic make_keystream(input key_t k);
		byte_t kb [KEY_BYTES];
		byte_t t;
		int i;
		int j;
		int n;
		kb[0] = k[23:16];
		kb[1] = k[15:8];
		kb[2] = k[7:0];
		for (i = 0; i < 256; i++)
			s_model[i] = byte_t'(i);
		j = 0;
		for (i = 0; i < 256; i++)	// key schedule
		begin
			j = (j + int'(s_model[i]) + int'(kb[i % KEY_BYTES])) % 256;
			t = s_model[i];
			s_model[i] = s_model[j];
			s_model[j] = t;
		end
		i = 0;
		j = 0;
		for (n = 0; n < MSG_LEN; n++)	// output generator
		begin
			i = (i + 1) % 256;
			j = (j + int'(s_model[i])) % 256;
			t = s_model[i];
			s_model[i] = s_model[j];
			s_model[j] = t;
			ks[n] = s_model[(int'(s_model[i]) + int'(s_model[j])) % 256];
		end
	endtask

	// random letters and spaces, encrypted with k
	task automatic new_message(input key_t k);
		int n;
		int r;
		make_keystream(k);
		for (n = 0; n < MSG_LEN; n++)
		begin
			r = $urandom % 27;
			msg[n] = (r == 26) ? CHAR_SPACE : byte_t'(CHAR_LO + r);
			cipher[n] = msg[n] ^ ks[n];
		end
	endtask

	// first accepted key from first upward, or KEY_LAST with no find
	task automatic predict(input key_t first);
		key_t k;
		bit ok;
		int n;
		k = first;
		pred_found = 1'b0;
		pred_key = first;
		while (!pred_found)
		begin
			make_keystream(k);
			ok = 1'b1;
			for (n = 0; n < MSG_LEN; n++)
				if (!char_valid(cipher[n] ^ ks[n]))
					ok = 1'b0;
			pred_key = k;
			if (ok)
				pred_found = 1'b1;
			else if (k == KEY_LAST)
				break;
			else
				k = k + 1'b1;
		end
	endtask

	task automatic load_cipher();
		int n;
		for (n = 0; n < MSG_LEN; n++)
		begin
			cipher_wr = 1'b1;
			cipher_addr = maddr_t'(n);
			cipher_data = cipher[n];
			step();
		end
		cipher_wr = 1'b0;
	endtask

	task automatic launch(input key_t first);
		key_start = first;
		start = 1'b1;
		step();
		start = 1'b0;	// done from a previous run has fallen by now
	endtask

	task automatic wait_done();
		while (!done)
			step();
		step();	// checker sees the rise on this edge
	endtask

	task automatic run_search(input key_t first);
		predict(first);
		exp_key = pred_key;
		exp_found = pred_found;
		key_chk = 1'b1;
		armed = 1'b1;
		launch(first);
		wait_done();
		armed = 1'b0;
	endtask

	// address k out, its byte checked one edge later
	task automatic read_plain();
		int n;
		for (n = 0; n <= MSG_LEN; n++)
		begin
			if (n < MSG_LEN)
				plain_addr = maddr_t'(n);
			plain_chk = (n > 0);
			if (n > 0)
			begin
				plain_idx = maddr_t'(n - 1);
				exp_plain = msg[n - 1];
			end
			step();
		end
		plain_chk = 1'b0;
	endtask

	initial
	begin
		int n;
		int wait_cycles;
		void'($urandom(32'hb28f));
		reset = 1'b1;
		start = 1'b0;
		stop = 1'b0;
		key_start = '0;
		cipher_wr = 1'b0;
		cipher_addr = '0;
		cipher_data = '0;
		plain_addr = '0;
		test_name = "reset";
		idle_chk = 1'b0;
		armed = 1'b0;
		key_chk = 1'b0;
		exp_key = '0;
		exp_found = 1'b0;
		plain_chk = 1'b0;
		plain_idx = '0;
		exp_plain = '0;
		repeat (4) @(posedge clk);
		#5 reset = 1'b0;
		step();
		idle_chk = 1'b1;	// nothing started yet
		step();
		idle_chk = 1'b0;

		for (n = 0; n < FIND_CASES; n++)
		begin
			secret = key_t'(3 + $urandom % (KEY_LAST - 3));
			new_message(secret);
			load_cipher();
			test_name = "find";
			run_search(secret - key_t'($urandom % 4));
			test_name = "readback";
			read_plain();
		end

		// no key in the last three fits this cipher
		secret = key_t'($urandom % 100);
		new_message(secret);
		load_cipher();
		test_name = "exhaust";
		run_search(KEY_LAST - 2);

		secret = key_t'(1000 + $urandom % (KEY_LAST - 1000));
		new_message(secret);
		load_cipher();
		test_name = "stop";
		key_chk = 1'b0;	// key at the stop is not known
		exp_found = 1'b0;
		armed = 1'b1;
		launch(secret - 1000);
		wait_cycles = 100 + $urandom % 2901;
		repeat (wait_cycles) step();
		stop = 1'b1;
		step();
		stop = 1'b0;
		wait_done();
		armed = 1'b0;
		test_name = "restart";	// search again from DONE
		run_search(secret - key_t'($urandom % 4));
		read_plain();

		$display("checks finished, errors: %0d", errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// watchdog over the whole run
	initial
	begin
		repeat (WATCH_CYCLES) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles, errors so far: %0d",
			WATCH_CYCLES, errors);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
rtl/rc4_pkg.sv
rtl/mem_bus_if.sv
rtl/sync_ram.sv
rtl/s_init_engine.sv
rtl/ksa_engine.sv
rtl/prga_engine.sv
rtl/key_search.sv
rtl/rc4_cracker_top.sv
bench/tb_checker.sv
bench/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the RC4 key search testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_top -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1
